// ==== vlog.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/slave_if.sv
hdl/bus_decoder.sv
hdl/sram_slave.sv
hdl/led_slave.sv
hdl/axi_led_bus_top.sv
tb/tb_axi_led_bus.sv

// ==== tb/bus_trace.txt ====
# op addr wdata strb btn  then expected: resp rdata led  (all hex)
# reads ignore wdata and strb, writes ignore rdata
W 00000000 11223344 f 0 0 00000000 00
W 00000004 aabbccdd f 0 0 00000000 00
W 00000000 55667788 5 0 0 00000000 00
R 00000000 00000000 0 0 0 11663388 00
W 00000004 eeff0011 a 0 0 00000000 00
R 00000004 00000000 0 0 0 eebb00dd 00
W 00000008 01020304 f 0 0 00000000 00
W 00000008 ffffffff 8 0 0 00000000 00
R 00000008 00000000 0 0 0 ff020304 00
R 00000100 00000000 0 0 0 11663388 00
R 00000104 00000000 0 0 0 eebb00dd 00
W 00000200 deadbeef 3 0 0 00000000 00
R 00000000 00000000 0 0 0 1166beef 00
W 000000fc cafef00d f 0 0 00000000 00
R 0ffffffc 00000000 0 0 0 cafef00d 00
W 20000000 12345678 f 0 0 00000000 78
R 20000000 00000000 0 0 0 12345678 78
W 20000000 000000a5 1 0 0 00000000 a5
R 20000000 00000000 0 0 0 123456a5 a5
W 20000000 ffff0000 c 0 0 00000000 a5
R 20000000 00000000 0 0 0 ffff56a5 a5
R 20000004 00000000 0 9 0 00000009 a5
R 20000004 00000000 0 6 0 00000006 a5
W 20000004 00000000 f 6 2 00000000 a5
R 20000008 00000000 0 6 2 00000000 a5
W 2000000c 00000011 f 6 2 00000000 a5
R 20000000 00000000 0 6 0 ffff56a5 a5
W 10000000 12345678 f 6 3 00000000 a5
R 10000000 00000000 0 6 3 00000000 a5
R 30000000 00000000 0 6 3 00000000 a5
W 30000010 ffffffff f 6 3 00000000 a5
R f0000000 00000000 0 6 3 00000000 a5
R 00000008 00000000 0 6 0 ff020304 a5

// ==== tb/tb_axi_led_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_led_bus;

    logic           clk;
    logic           rst;
    bus_pkg::addr_t wr_addr;
    bus_pkg::data_t wr_data;
    bus_pkg::strb_t wr_strb;
    logic           wr_valid;
    logic           wr_ready;
    bus_pkg::resp_t wr_resp;
    logic           wr_resp_valid;
    logic           wr_resp_ready;
    bus_pkg::addr_t rd_addr;
    logic           rd_valid;
    logic           rd_ready;
    bus_pkg::data_t rd_data;
    bus_pkg::resp_t rd_resp;
    logic           rd_data_valid;
    logic           rd_data_ready;
    bus_pkg::btn_t  btn;
    bus_pkg::led_t  led;

    // trace columns
    bit             t_write [$];
    bus_pkg::addr_t t_addr  [$];
    bus_pkg::data_t t_wdata [$];
    bus_pkg::strb_t t_strb  [$];
    bus_pkg::btn_t  t_btn   [$];
    bus_pkg::resp_t t_resp  [$];
    bus_pkg::data_t t_rdata [$];
    bus_pkg::led_t  t_led   [$];

    logic [31:0] lfsr_state = 32'h35e2db82;
    bit          trace_loaded = 1'b0;

    axi_led_bus_top i_axi_led_bus_top (
        .bus_clk       (clk          ),
        .rst           (rst          ),
        .wr_addr       (wr_addr      ),
        .wr_data       (wr_data      ),
        .wr_strb       (wr_strb      ),
        .wr_valid      (wr_valid     ),
        .wr_ready      (wr_ready     ),
        .wr_resp       (wr_resp      ),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .rd_addr       (rd_addr      ),
        .rd_valid      (rd_valid     ),
        .rd_ready      (rd_ready     ),
        .rd_data       (rd_data      ),
        .rd_resp       (rd_resp      ),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .btn           (btn          ),
        .led           (led          )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input bus_pkg::resp_t got,
                              input bus_pkg::resp_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                                $time, name, got, exp));
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t got,
                              input bus_pkg::data_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s got %08h expected %08h",
                                $time, name, got, exp));
    endtask

    task automatic check_led(input string name, input bus_pkg::led_t got,
                             input bus_pkg::led_t exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: %s got %02h expected %02h",
                                $time, name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_stall(output int cycles);
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            cycles = cycles | (int'(lfsr_state[0]) << b);
        end
    endtask

    task automatic load_trace;
        int                 fd;
        int                 n;
        logic [8*160-1:0]   line_buf;
        logic [8*8-1:0]     op_tok;
        logic [31:0]        f [0:6];
        fd = $fopen("tb/bus_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open tb/bus_trace.txt");
        while (!$feof(fd)) begin
            line_buf = '0;
            op_tok = '0;
            if ($fgets(line_buf, fd) == 0)
                continue;
            n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h",
                        op_tok, f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (n <= 0 || op_tok[7:0] == "#")
                continue;   // blank or comment
            if (n != 8 || (op_tok[7:0] != "W" && op_tok[7:0] != "R"))
                abort_run("malformed line in the trace file");
            t_write.push_back(op_tok[7:0] == "W");
            t_addr.push_back(f[0]);
            t_wdata.push_back(f[1]);
            t_strb.push_back(f[2][3:0]);
            t_btn.push_back(f[3][3:0]);
            t_resp.push_back(f[4][1:0]);
            t_rdata.push_back(f[5]);
            t_led.push_back(f[6][7:0]);
        end
        $fclose(fd);
        if (t_write.size() == 0)
            abort_run("trace file holds no transactions");
    endtask

    function automatic logic resp_valid_of(input bit is_wr);
        return is_wr ? wr_resp_valid : rd_data_valid;
    endfunction

    task automatic check_result(input int i);
        if (t_write[i]) begin
            if (rd_data_valid)
                abort_run("read response valid raised during a write");
            check_resp("wr_resp", wr_resp, t_resp[i]);
        end else begin
            if (wr_resp_valid)
                abort_run("write response valid raised during a read");
            check_resp("rd_resp", rd_resp, t_resp[i]);
            check_data("rd_data", rd_data, t_rdata[i]);
        end
    endtask

    task automatic run_txn(input int i);
        int stall;
        @(posedge clk);
        btn <= t_btn[i];
        repeat (4) @(posedge clk);  // covers the button sync
        draw_stall(stall);
        if (t_write[i]) begin
            wr_addr  <= t_addr[i];
            wr_data  <= t_wdata[i];
            wr_strb  <= t_strb[i];
            wr_valid <= 1'b1;
        end else begin
            rd_addr  <= t_addr[i];
            rd_valid <= 1'b1;
        end
        do @(negedge clk); while (!(t_write[i] ? wr_ready : rd_ready));
        @(posedge clk);             // request handshake
        wr_valid <= 1'b0;
        rd_valid <= 1'b0;
        do @(negedge clk); while (!resp_valid_of(t_write[i]));
        check_result(i);
        // response must hold while ready is low
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            if (!resp_valid_of(t_write[i]))
                abort_run("response valid dropped while ready was low");
            check_result(i);
        end
        @(posedge clk);
        wr_resp_ready <= 1'b1;
        rd_data_ready <= 1'b1;
        @(posedge clk);             // response handshake
        wr_resp_ready <= 1'b0;
        rd_data_ready <= 1'b0;
        @(negedge clk);
        if (wr_resp_valid || rd_data_valid)
            abort_run("response valid still high after the handshake");
        check_led("led", led, t_led[i]);
    endtask

    initial begin
        wait (trace_loaded);
        repeat (t_write.size() * 40 + 100) @(posedge clk);
        abort_run("watchdog expired before the trace completed");
    end

    initial begin
        rst           = 1'b1;
        wr_addr       = '0;
        wr_data       = '0;
        wr_strb       = '0;
        wr_valid      = 1'b0;
        wr_resp_ready = 1'b0;
        rd_addr       = '0;
        rd_valid      = 1'b0;
        rd_data_ready = 1'b0;
        btn           = '0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < t_write.size(); i++)
            run_txn(i);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/axi_led_bus_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_led_bus_top (
    input  wire            bus_clk,
    input  wire            rst,
    // write request
    input  bus_pkg::addr_t wr_addr,
    input  bus_pkg::data_t wr_data,
    input  bus_pkg::strb_t wr_strb,
    input  wire            wr_valid,
    output logic           wr_ready,
    // write response
    output bus_pkg::resp_t wr_resp,
    output logic           wr_resp_valid,
    input  wire            wr_resp_ready,
    // read request
    input  bus_pkg::addr_t rd_addr,
    input  wire            rd_valid,
    output logic           rd_ready,
    // read response
    output bus_pkg::data_t rd_data,
    output bus_pkg::resp_t rd_resp,
    output logic           rd_data_valid,
    input  wire            rd_data_ready,
    // board io
    input  bus_pkg::btn_t  btn,
    output bus_pkg::led_t  led
);

    slave_if mem_bus ();
    slave_if led_bus ();

    bus_decoder i_bus_decoder (
        .clk           (bus_clk      ),
        .rst           (rst          ),
        .wr_addr       (wr_addr      ),
        .wr_data       (wr_data      ),
        .wr_strb       (wr_strb      ),
        .wr_valid      (wr_valid     ),
        .wr_ready      (wr_ready     ),
        .wr_resp       (wr_resp      ),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp_ready (wr_resp_ready),
        .rd_addr       (rd_addr      ),
        .rd_valid      (rd_valid     ),
        .rd_ready      (rd_ready     ),
        .rd_data       (rd_data      ),
        .rd_resp       (rd_resp      ),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .mem           (mem_bus      ),
        .led           (led_bus      )
    );

    sram_slave i_sram_slave (   // region 0
        .clk (bus_clk),
        .rst (rst    ),
        .bus (mem_bus)
    );

    led_slave i_led_slave (     // region 2
        .clk (bus_clk),
        .rst (rst    ),
        .btn (btn    ),
        .led (led    ),
        .bus (led_bus)
    );

endmodule

`default_nettype wire

// ==== hdl/led_slave.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bus_cfg.svh"

module led_slave (
    input  wire            clk,
    input  wire            rst,
    input  bus_pkg::btn_t  btn,
    output bus_pkg::led_t  led,
    slave_if.slave         bus
);

    bus_pkg::data_t          led_reg;
    bus_pkg::btn_t           btn_meta;
    bus_pkg::btn_t           btn_sync;
    logic [`REGION_LSB-3:0]  word_off;
    logic                    valid_off;
    logic                    bad_access;

    assign word_off   = bus.req_addr[`REGION_LSB-1:2];
    assign valid_off  = (word_off < `LED_REG_COUNT);
    // button word is read only
    assign bad_access = !valid_off || (word_off[0] && bus.req_write);

    // two-flop sync for the async buttons
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            led_reg       <= '0;
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= bus.req_valid;
            if (bus.req_valid && bus.req_write && !bad_access) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.req_strb[b])
                        led_reg[8*b +: 8] <= bus.req_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req_valid) begin
            if (bad_access) begin
                bus.rsp_rdata <= '0;
                bus.rsp_resp  <= `RESP_SLVERR;
            end else if (word_off[0]) begin
                bus.rsp_rdata <= {28'd0, btn_sync};
                bus.rsp_resp  <= `RESP_OKAY;
            end else begin
                bus.rsp_rdata <= led_reg;   // pre-write value
                bus.rsp_resp  <= `RESP_OKAY;
            end
        end
    end

    assign led = led_reg[7:0];

    a_latency: assert property (@(posedge clk) disable iff (rst)
        bus.req_valid |=> bus.rsp_valid);

endmodule

`default_nettype wire

// ==== hdl/sram_slave.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bus_cfg.svh"

module sram_slave (
    input  wire     clk,
    input  wire     rst,
    slave_if.slave  bus
);

    localparam int idx_w = $clog2(`SRAM_DEPTH);

    bus_pkg::data_t   mem [0:`SRAM_DEPTH-1];
    logic [idx_w-1:0] idx;

    // word index, upper address bits alias
    assign idx = bus.req_addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (bus.req_valid && bus.req_write) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.req_strb[b])
                    mem[idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req_valid)
            bus.rsp_rdata <= mem[idx];  // old word on a write
    end

    always_ff @(posedge clk) begin
        if (rst)
            bus.rsp_valid <= 1'b0;
        else
            bus.rsp_valid <= bus.req_valid;
    end

    assign bus.rsp_resp = `RESP_OKAY;

    // one-cycle turnaround toward the decoder
    a_latency: assert property (@(posedge clk) disable iff (rst)
        bus.req_valid |=> bus.rsp_valid);

    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        bus.rsp_valid |-> $past(bus.req_valid));

endmodule

`default_nettype wire

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bus_cfg.svh"

module bus_decoder (
    input  wire            clk,
    input  wire            rst,
    input  bus_pkg::addr_t wr_addr,
    input  bus_pkg::data_t wr_data,
    input  bus_pkg::strb_t wr_strb,
    input  wire            wr_valid,
    output logic           wr_ready,
    output bus_pkg::resp_t wr_resp,
    output logic           wr_resp_valid,
    input  wire            wr_resp_ready,
    input  bus_pkg::addr_t rd_addr,
    input  wire            rd_valid,
    output logic           rd_ready,
    output bus_pkg::data_t rd_data,
    output bus_pkg::resp_t rd_resp,
    output logic           rd_data_valid,
    input  wire            rd_data_ready,
    slave_if.decoder       mem,
    slave_if.decoder       led
);

    localparam bus_pkg::addr_t sram_base = `SRAM_BASE;
    localparam bus_pkg::addr_t led_base  = `LED_BASE;

    bus_pkg::dec_state_t state;
    logic                is_write;
    logic                sel_mem;
    logic                sel_led;
    logic                wr_acc;
    logic                rd_acc;
    logic                rsp_hit;
    bus_pkg::addr_t      acc_addr;
    logic [`REGION_MSB-`REGION_LSB:0] region;
    bus_pkg::addr_t      addr_q;
    bus_pkg::data_t      wdata_q;
    bus_pkg::strb_t      strb_q;
    bus_pkg::data_t      rdata_q;
    bus_pkg::resp_t      resp_q;

    assign wr_ready = (state == bus_pkg::IDLE);
    assign rd_ready = (state == bus_pkg::IDLE) && !wr_valid;  // write has priority
    assign wr_acc   = wr_valid && wr_ready;
    assign rd_acc   = rd_valid && rd_ready;
    assign acc_addr = wr_valid ? wr_addr : rd_addr;
    assign region   = acc_addr[`REGION_MSB:`REGION_LSB];

    // unmapped region needs no slave answer
    assign rsp_hit = (sel_mem && mem.rsp_valid) || (sel_led && led.rsp_valid) ||
                     !(sel_mem || sel_led);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= bus_pkg::IDLE;
            is_write <= 1'b0;
            sel_mem  <= 1'b0;
            sel_led  <= 1'b0;
        end else begin
            case (state)
                bus_pkg::IDLE: begin
                    if (wr_acc || rd_acc) begin
                        is_write <= wr_acc;
                        sel_mem  <= (region == sram_base[`REGION_MSB:`REGION_LSB]);
                        sel_led  <= (region == led_base[`REGION_MSB:`REGION_LSB]);
                        state    <= bus_pkg::ISSUE;
                    end
                end
                bus_pkg::ISSUE: state <= bus_pkg::WAIT;
                bus_pkg::WAIT: begin
                    if (rsp_hit)
                        state <= bus_pkg::RESP;
                end
                bus_pkg::RESP: begin
                    if (is_write ? wr_resp_ready : rd_data_ready)
                        state <= bus_pkg::IDLE;
                end
                default: state <= bus_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_pkg::IDLE) begin
            addr_q  <= acc_addr;
            wdata_q <= wr_data;
            strb_q  <= wr_strb;
        end
        if (state == bus_pkg::WAIT && rsp_hit) begin
            if (sel_mem) begin
                rdata_q <= mem.rsp_rdata;
                resp_q  <= mem.rsp_resp;
            end else if (sel_led) begin
                rdata_q <= led.rsp_rdata;
                resp_q  <= led.rsp_resp;
            end else begin
                rdata_q <= '0;
                resp_q  <= `RESP_DECERR;
            end
        end
    end

    assign mem.req_valid = (state == bus_pkg::ISSUE) && sel_mem;
    assign mem.req_write = is_write;
    assign mem.req_addr  = addr_q;
    assign mem.req_wdata = wdata_q;
    assign mem.req_strb  = strb_q;

    assign led.req_valid = (state == bus_pkg::ISSUE) && sel_led;
    assign led.req_write = is_write;
    assign led.req_addr  = addr_q;
    assign led.req_wdata = wdata_q;
    assign led.req_strb  = strb_q;

    assign wr_resp       = resp_q;
    assign wr_resp_valid = (state == bus_pkg::RESP) && is_write;
    assign rd_data       = rdata_q;
    assign rd_resp       = resp_q;
    assign rd_data_valid = (state == bus_pkg::RESP) && !is_write;

    a_one_slave: assert property (@(posedge clk) disable iff (rst)
        !(mem.req_valid && led.req_valid));

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(wr_resp_valid && rd_data_valid));

    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        (wr_resp_valid && !wr_resp_ready) |=> (wr_resp_valid && $stable(wr_resp)));

    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        (rd_data_valid && !rd_data_ready) |=>
            (rd_data_valid && $stable(rd_data) && $stable(rd_resp)));

endmodule

`default_nettype wire

// ==== hdl/slave_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// single-beat request/response between decoder and one slave
interface slave_if;

    logic           req_valid;  // one-cycle strobe
    logic           req_write;
    bus_pkg::addr_t req_addr;
    bus_pkg::data_t req_wdata;
    bus_pkg::strb_t req_strb;

    logic           rsp_valid;  // cycle after req_valid
    bus_pkg::data_t rsp_rdata;
    bus_pkg::resp_t rsp_resp;

    modport decoder (
        output req_valid, req_write, req_addr, req_wdata, req_strb,
        input  rsp_valid, rsp_rdata, rsp_resp
    );

    modport slave (
        input  req_valid, req_write, req_addr, req_wdata, req_strb,
        output rsp_valid, rsp_rdata, rsp_resp
    );

endinterface

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;    // one bit per byte lane
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  btn_t;
    typedef logic [7:0]  led_t;

    // decoder transaction states
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        RESP
    } dec_state_t;

endpackage

`default_nettype wire

// ==== hdl/bus_cfg.svh ====
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// region map, selected by the top address nibble
`define SRAM_BASE       32'h0000_0000
`define LED_BASE        32'h2000_0000
`define REGION_MSB      31
`define REGION_LSB      28

`define SRAM_DEPTH      64      // 32-bit words
`define LED_REG_COUNT   2       // led word + button word

// response codes
`define RESP_OKAY       2'd0
`define RESP_SLVERR     2'd2
`define RESP_DECERR     2'd3

`endif
